// File: life.f
rtl/life_pkg.sv
rtl/row_ram.sv
rtl/mem_arbiter.sv
rtl/host_port.sv
rtl/sweep_ctrl.sv
rtl/gen_stage.sv
rtl/life_top.sv
sim/life_handshake_checker.sv
sim/life_tb.sv

// File: rtl/gen_stage.sv
// one life generation on a streaming row window
// vertical tallies registered, horizontal sum wraps at the row ends
`default_nettype none
`timescale 1ns/1ps

module gen_stage #(
	parameter int WIDTH = life_pkg::DEFAULT_WIDTH
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               clear,
	input  logic [WIDTH-1:0]   in_row,
	input  logic               in_valid,
	output logic [WIDTH-1:0]   out_row,
	output logic               out_valid
);

	logic [WIDTH-1:0]      row_a;     // most recent row in
	logic [WIDTH-1:0]      row_b;     // row before that
	logic [WIDTH-1:0][1:0] tally;     // vertical 3-cell counts
	logic [WIDTH-1:0]      centre;    // middle row of the tallied window
	logic [WIDTH-1:0][3:0] sum9;      // full 3x3 count incl. centre
	logic [WIDTH-1:0]      next_row;
	logic [1:0]            fill;      // rows held, saturates at 2
	logic                  sum_valid; // tally/centre hold a full window

	////////////////////////////////////////
	// window and vertical tally
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (in_valid) begin
			row_b  <= row_a;
			row_a  <= in_row;
			centre <= row_a; // previous input row is the one being updated
			for (int x = 0; x < WIDTH; x++) begin
				tally[x] <= {1'b0, row_b[x]} + {1'b0, row_a[x]} + {1'b0, in_row[x]};
			end
		end
	end

	// horizontal sum with wrap, then the rule
	always_comb begin
		for (int x = 0; x < WIDTH; x++) begin
			sum9[x] = {2'b00, tally[(x + WIDTH - 1) % WIDTH]}
				+ {2'b00, tally[x]}
				+ {2'b00, tally[(x + 1) % WIDTH]};
			// 3 -> birth or survive on 2, 4 with centre alive -> survive on 3
			next_row[x] = (sum9[x] == 4'd3) || (sum9[x] == 4'd4 && centre[x]);
		end
	end

	always_ff @(posedge clk) begin
		if (sum_valid) begin
			out_row <= next_row;
		end
	end

	////////////////////////////////////////
	// fill count and valid pipe
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst || clear) begin
			fill      <= '0;
			sum_valid <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			sum_valid <= in_valid && (fill == 2'd2); // first two rows only prime the window
			out_valid <= sum_valid;
			if (in_valid && fill != 2'd2) begin
				fill <= fill + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/host_port.sv
// host command port, four-phase req/ack
// runs row write, row read and step, holds ack until req falls
`default_nettype none
`timescale 1ns/1ps

module host_port #(
	parameter int WIDTH = life_pkg::DEFAULT_WIDTH,
	parameter int DEPTH = life_pkg::DEFAULT_DEPTH
) (
	input  logic                       clk,
	input  logic                       rst,
	// host handshake
	input  logic                       req,
	input  life_pkg::host_op_e         op,
	input  logic [$clog2(DEPTH)-1:0]   row,
	input  logic [WIDTH-1:0]           wdata,
	output logic                       ack,
	output logic [WIDTH-1:0]           rdata,
	// memory access through the arbiter
	output logic                       hreq,
	output logic                       hwe,
	output logic [$clog2(DEPTH)-1:0]   hrow,
	output logic [WIDTH-1:0]           hwdata,
	input  logic                       hgnt,
	input  logic [WIDTH-1:0]           mem_rdata,
	// sweep control
	output logic                       step_start,
	input  logic                       step_done
);

	import life_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,    // waiting for req
		S_ACCESS,  // hreq up until granted
		S_CAPTURE, // read word on mem_rdata
		S_STEP,    // sweep running
		S_ACK      // ack up until req drops
	} state_e;

	state_e state;

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= S_IDLE;
			step_start <= 1'b0;
		end else begin
			step_start <= 1'b0; // single-cycle pulse
			case (state)
				S_IDLE: if (req) begin
					if (op == OP_STEP) begin
						step_start <= 1'b1;
						state      <= S_STEP;
					end else begin
						state <= S_ACCESS;
					end
				end
				S_ACCESS:  if (hgnt) state <= hwe ? S_ACK : S_CAPTURE;
				S_CAPTURE: state <= S_ACK; // data was latched this cycle
				S_STEP:    if (step_done) state <= S_ACK;
				S_ACK:     if (!req) state <= S_IDLE;
				default:   state <= S_IDLE;
			endcase
		end
	end

	// command payload, taken when the command is accepted
	always_ff @(posedge clk) begin
		if (state == S_IDLE && req) begin
			hwe    <= (op == OP_WRITE);
			hrow   <= row;
			hwdata <= wdata;
		end
		if (state == S_CAPTURE) begin
			rdata <= mem_rdata; // held through the ack phase
		end
	end

	assign hreq = (state == S_ACCESS);
	assign ack  = (state == S_ACK);

endmodule

`default_nettype wire

// File: rtl/life_pkg.sv
// life engine shared definitions
// host command encoding and default board geometry
`default_nettype none

package life_pkg;

	////////////////////////////////////////
	// host commands
	////////////////////////////////////////

	// two-bit op field on the host port
	typedef enum logic [1:0] {
		OP_WRITE = 2'd0, // load one row into the front bank
		OP_READ  = 2'd1, // fetch one row from the front bank
		OP_STEP  = 2'd2  // one full sweep, GENS generations
	} host_op_e;

	////////////////////////////////////////
	// default board geometry
	////////////////////////////////////////

	// columns per row, one memory word per row
	localparam int DEFAULT_WIDTH = 16;

	// rows on the torus
	localparam int DEFAULT_DEPTH = 12;

	// generation stages chained per sweep
	// must stay below DEPTH so the wrapped read window makes sense
	localparam int DEFAULT_GENS = 2;

endpackage

`default_nettype wire

// File: rtl/life_top.sv
// toroidal life engine top level
// host port, arbiter, two-bank row memory, sweep and GENS stages
`default_nettype none
`timescale 1ns/1ps

module life_top #(
	parameter int WIDTH = life_pkg::DEFAULT_WIDTH,
	parameter int DEPTH = life_pkg::DEFAULT_DEPTH,
	parameter int GENS  = life_pkg::DEFAULT_GENS
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       req,
	input  life_pkg::host_op_e         op,
	input  logic [$clog2(DEPTH)-1:0]   row,
	input  logic [WIDTH-1:0]           wdata,
	output logic                       ack,
	output logic [WIDTH-1:0]           rdata
);

	// host <-> arbiter
	logic                     hreq, hwe, hgnt;
	logic [$clog2(DEPTH)-1:0] hrow;
	logic [WIDTH-1:0]         hwdata;
	// sweep <-> arbiter / host
	logic                     sreq, sgnt, sre, swe, swap;
	logic [$clog2(DEPTH)-1:0] srow, swrow;
	logic [WIDTH-1:0]         swdata;
	logic                     step_start, step_done, clear;
	// arbiter -> memory
	logic                     ram_re, ram_we;
	logic [$clog2(DEPTH):0]   ram_raddr, ram_waddr;
	logic [WIDTH-1:0]         ram_wdata;
	// stage chain, index 0 is the memory read data
	logic [GENS:0][WIDTH-1:0] st_row;
	logic [GENS:0]            st_valid;

	host_port #(.WIDTH(WIDTH), .DEPTH(DEPTH)) u_host (
		.clk(clk), .rst(rst), .req(req), .op(op), .row(row), .wdata(wdata),
		.ack(ack), .rdata(rdata), .hreq(hreq), .hwe(hwe), .hrow(hrow),
		.hwdata(hwdata), .hgnt(hgnt), .mem_rdata(st_row[0]),
		.step_start(step_start), .step_done(step_done)
	);

	mem_arbiter #(.WIDTH(WIDTH), .DEPTH(DEPTH)) u_arb (
		.clk(clk), .rst(rst), .hreq(hreq), .hwe(hwe), .hrow(hrow),
		.hwdata(hwdata), .hgnt(hgnt), .sreq(sreq), .sgnt(sgnt), .sre(sre),
		.srow(srow), .swe(swe), .swrow(swrow), .swdata(swdata), .swap(swap),
		.ram_re(ram_re), .ram_raddr(ram_raddr), .ram_we(ram_we),
		.ram_waddr(ram_waddr), .ram_wdata(ram_wdata)
	);

	row_ram #(.WIDTH(WIDTH), .DEPTH(DEPTH)) u_ram (
		.clk(clk), .re(ram_re), .raddr(ram_raddr), .we(ram_we),
		.waddr(ram_waddr), .wdata(ram_wdata), .rdata(st_row[0])
	);

	sweep_ctrl #(.WIDTH(WIDTH), .DEPTH(DEPTH), .GENS(GENS)) u_sweep (
		.clk(clk), .rst(rst), .step_start(step_start), .step_done(step_done),
		.sreq(sreq), .sgnt(sgnt), .sre(sre), .srow(srow), .swe(swe),
		.swrow(swrow), .swdata(swdata), .swap(swap), .clear(clear),
		.first_valid(st_valid[0]), .last_row(st_row[GENS]),
		.last_valid(st_valid[GENS])
	);

	// one stage per generation, each narrows the stream by two rows
	for (genvar g = 0; g < GENS; g++) begin : g_stage
		gen_stage #(.WIDTH(WIDTH)) u_stage (
			.clk(clk), .rst(rst), .clear(clear),
			.in_row(st_row[g]), .in_valid(st_valid[g]),
			.out_row(st_row[g+1]), .out_valid(st_valid[g+1])
		);
	end

endmodule

`default_nettype wire

// File: rtl/mem_arbiter.sv
// row memory arbiter between host port and sweep
// sweep has priority and keeps the grant until sreq drops
// owns the front-bank bit, toggled on swap
`default_nettype none
`timescale 1ns/1ps

module mem_arbiter #(
	parameter int WIDTH = life_pkg::DEFAULT_WIDTH,
	parameter int DEPTH = life_pkg::DEFAULT_DEPTH
) (
	input  logic                       clk,
	input  logic                       rst,
	// host side
	input  logic                       hreq,
	input  logic                       hwe,
	input  logic [$clog2(DEPTH)-1:0]   hrow,
	input  logic [WIDTH-1:0]           hwdata,
	output logic                       hgnt,
	// sweep side
	input  logic                       sreq,
	output logic                       sgnt,
	input  logic                       sre,
	input  logic [$clog2(DEPTH)-1:0]   srow,
	input  logic                       swe,
	input  logic [$clog2(DEPTH)-1:0]   swrow,
	input  logic [WIDTH-1:0]           swdata,
	input  logic                       swap,
	// memory side
	output logic                       ram_re,
	output logic [$clog2(DEPTH):0]     ram_raddr,
	output logic                       ram_we,
	output logic [$clog2(DEPTH):0]     ram_waddr,
	output logic [WIDTH-1:0]           ram_wdata
);

	logic front; // bank holding the current board

	////////////////////////////////////////
	// ownership
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			sgnt  <= 1'b0;
			front <= 1'b0;
		end else begin
			sgnt <= sreq; // locked for as long as sreq stays up
			if (swap) begin
				front <= ~front; // back bank now holds the new board
			end
		end
	end

	// host served only when the sweep neither asks nor owns
	assign hgnt = hreq & ~sreq & ~sgnt;

	////////////////////////////////////////
	// address and data steering
	////////////////////////////////////////

	// sweep reads front, writes back; host always on front
	assign ram_re    = sgnt ? sre : (hgnt & ~hwe);
	assign ram_raddr = sgnt ? {front, srow} : {front, hrow};
	assign ram_we    = sgnt ? swe : (hgnt & hwe);
	assign ram_waddr = sgnt ? {~front, swrow} : {front, hrow};
	assign ram_wdata = sgnt ? swdata : hwdata;

endmodule

`default_nettype wire

// File: rtl/row_ram.sv
// two-bank row memory, one read and one write port
// read data registered, one cycle after the address
`default_nettype none
`timescale 1ns/1ps

module row_ram #(
	parameter int WIDTH = life_pkg::DEFAULT_WIDTH,
	parameter int DEPTH = life_pkg::DEFAULT_DEPTH
) (
	input  logic                     clk,
	input  logic                     re,
	input  logic [$clog2(DEPTH):0]   raddr, // {bank, row}
	input  logic                     we,
	input  logic [$clog2(DEPTH):0]   waddr, // {bank, row}
	input  logic [WIDTH-1:0]         wdata,
	output logic [WIDTH-1:0]         rdata
);

	localparam int RW = $clog2(DEPTH); // row index bits

	// bank 0 and bank 1, DEPTH rows each
	logic [WIDTH-1:0] mem [0:1][0:DEPTH-1];

	// write port
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr[RW]][waddr[RW-1:0]] <= wdata;
		end
	end

	// read port, holds last word when re is low
	always_ff @(posedge clk) begin
		if (re) begin
			rdata <= mem[raddr[RW]][raddr[RW-1:0]];
		end
	end

endmodule

`default_nettype wire

// File: rtl/sweep_ctrl.sv
// sweep controller for one step
// streams DEPTH+2*GENS wrapped rows out of the front bank
// and writes final-stage rows 0..DEPTH-1 into the back bank
`default_nettype none
`timescale 1ns/1ps

module sweep_ctrl #(
	parameter int WIDTH = life_pkg::DEFAULT_WIDTH,
	parameter int DEPTH = life_pkg::DEFAULT_DEPTH,
	parameter int GENS  = life_pkg::DEFAULT_GENS
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       step_start,
	output logic                       step_done,
	// arbiter side
	output logic                       sreq,
	input  logic                       sgnt,
	output logic                       sre,
	output logic [$clog2(DEPTH)-1:0]   srow,
	output logic                       swe,
	output logic [$clog2(DEPTH)-1:0]   swrow,
	output logic [WIDTH-1:0]           swdata,
	output logic                       swap,
	// stage chain
	output logic                       clear,
	output logic                       first_valid,
	input  logic [WIDTH-1:0]           last_row,
	input  logic                       last_valid
);

	localparam int RW     = $clog2(DEPTH);
	localparam int NREADS = DEPTH + 2*GENS;            // rows streamed per sweep
	localparam int CW     = $clog2(NREADS + 1);
	localparam int START  = (DEPTH - (GENS % DEPTH)) % DEPTH; // GENS rows above row 0

	logic [CW-1:0] rd_cnt; // reads issued so far
	logic [RW-1:0] wr_cnt; // back-bank row being written

	// one read per cycle once granted, no back-pressure
	assign sre = sreq & sgnt & (rd_cnt != CW'(NREADS));

	// final stage output goes straight to the back bank
	assign swe    = sreq & last_valid;
	assign swrow  = wr_cnt;
	assign swdata = last_row;
	assign swap   = step_done; // bank flip with the done pulse

	always_ff @(posedge clk) begin
		if (rst) begin
			sreq        <= 1'b0;
			clear       <= 1'b0;
			first_valid <= 1'b0;
			step_done   <= 1'b0;
			rd_cnt      <= '0;
			wr_cnt      <= '0;
			srow        <= '0;
		end else begin
			clear       <= step_start; // empty the windows before data arrives
			first_valid <= sre;        // ram data lands a cycle after the address
			step_done   <= 1'b0;

			if (step_start) begin
				sreq   <= 1'b1;
				rd_cnt <= '0;
				wr_cnt <= '0;
				srow   <= RW'(START);
			end

			// read address, wraps modulo DEPTH
			if (sre) begin
				rd_cnt <= rd_cnt + 1'b1;
				srow   <= (srow == RW'(DEPTH-1)) ? '0 : srow + 1'b1;
			end

			// write side ends the sweep
			if (swe) begin
				wr_cnt <= wr_cnt + 1'b1;
				if (wr_cnt == RW'(DEPTH-1)) begin
					sreq      <= 1'b0; // releases the memory
					step_done <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# builds the life engine testbench with Verilator and runs it
# the run passes only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module life_tb -f life.f; then
	echo "verilator build failed"
	exit 1
fi

if [ ! -x ./obj_dir/Vlife_tb ]; then
	echo "simulation binary missing"
	exit 1
fi

./obj_dir/Vlife_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
fi

if grep -qx "NO ERRORS" "$LOG"; then
	exit 0
fi

echo "simulation failed, see $LOG"
exit 1

// File: sim/life_handshake_checker.sv
// host handshake checker bound into the life engine top
// four-phase req/ack ordering and read data hold
`default_nettype none
`timescale 1ns/1ps

module life_handshake_checker #(
	parameter int WIDTH = life_pkg::DEFAULT_WIDTH
) (
	input logic             clk,
	input logic             rst,
	input logic             req,
	input logic             ack,
	input logic [WIDTH-1:0] rdata
);

	////////////////////////////////////////
	// four-phase rules
	////////////////////////////////////////

	ack_needs_req: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> req)
		else $error("ack rose while req was low");

	ack_held: assert property (@(posedge clk) disable iff (rst) (ack && req) |=> ack)
		else $error("ack dropped before req fell");

	// rdata frozen for the whole ack phase
	rdata_stable: assert property (@(posedge clk) disable iff (rst)
		(ack && $past(ack)) |-> (rdata === $past(rdata)))
		else $error("rdata changed while ack was high");

	ack_low_in_reset: assert property (@(posedge clk) rst |=> !ack)
		else $error("ack high during reset");

endmodule

bind life_top life_handshake_checker #(.WIDTH(WIDTH)) chk_i (
	.clk(clk), .rst(rst), .req(req), .ack(ack), .rdata(rdata)
);

`default_nettype wire

// File: sim/life_tb.sv
// testbench for the toroidal life engine
// command table with expected rows taken from a reference life model
`default_nettype none
`timescale 1ns/1ps

module life_tb;

	import life_pkg::*;

	localparam int WIDTH = 16;
	localparam int DEPTH = 12;
	localparam int GENS  = 2;
	localparam int RW    = $clog2(DEPTH);

	// pattern tags, also name the test in error lines
	localparam int T_OSC    = 0; // blinker plus block
	localparam int T_GLIDER = 1;
	localparam int T_RANDOM = 2;
	localparam int T_EMPTY  = 3;
	localparam int T_SINGLE = 4;

	logic             clk;
	logic             rst;
	logic             req;
	host_op_e         op;
	logic [RW-1:0]    row;
	logic [WIDTH-1:0] wdata;
	logic             ack;
	logic [WIDTH-1:0] rdata;

	// command table, one handshake per entry
	host_op_e         op_q[$];
	logic [RW-1:0]    row_q[$];
	logic [WIDTH-1:0] data_q[$]; // write data, or expected row for reads
	int               tag_q[$];

	logic [WIDTH-1:0] model [DEPTH]; // expected board, runs ahead of the DUT
	logic [15:0]      lfsr;
	int               err_count = 0;
	int               cycles    = 0;
	int               limit     = 0; // 0 until the table is built

	life_top #(.WIDTH(WIDTH), .DEPTH(DEPTH), .GENS(GENS)) dut_i (
		.clk(clk), .rst(rst), .req(req), .op(op), .row(row),
		.wdata(wdata), .ack(ack), .rdata(rdata)
	);

	////////////////////////////////////////
	// clock and timeout
	////////////////////////////////////////

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout: command table not finished after %0d cycles", limit);
			$display("ERRORS FOUND");
			$fatal(1, "run stopped by cycle limit");
		end
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	// 16-bit fibonacci lfsr, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic string tag_name(input int tag);
		case (tag)
			T_OSC:    return "blinker_block";
			T_GLIDER: return "glider_wrap";
			T_RANDOM: return "random_board";
			T_EMPTY:  return "empty_board";
			T_SINGLE: return "single_cell";
			default:  return "unknown";
		endcase
	endfunction

	task automatic check_value(input string name, input logic [WIDTH-1:0] exp,
			input logic [WIDTH-1:0] act);
		if (act !== exp) begin
			err_count++;
			$display("FAIL %s: expected %h actual %h", name, exp, act);
			$display("ERRORS FOUND");
			$fatal(1, "row mismatch");
		end
	endtask

	// one generation on the torus, straight from the rule: count 8 neighbours
	task automatic advance_model();
		logic [WIDTH-1:0] nxt [DEPTH];
		int n;
		for (int y = 0; y < DEPTH; y++) begin
			for (int x = 0; x < WIDTH; x++) begin
				n = 0;
				for (int dy = -1; dy <= 1; dy++) begin
					for (int dx = -1; dx <= 1; dx++) begin
						if (dy != 0 || dx != 0) begin
							n += int'(model[(y + dy + DEPTH) % DEPTH][(x + dx + WIDTH) % WIDTH]);
						end
					end
				end
				nxt[y][x] = (n == 3) || (n == 2 && model[y][x]); // birth on 3, survive on 2 or 3
			end
		end
		for (int y = 0; y < DEPTH; y++) begin
			model[y] = nxt[y];
		end
	endtask

	task automatic add_cmd(input host_op_e o, input int r, input logic [WIDTH-1:0] d,
			input int tag);
		op_q.push_back(o);
		row_q.push_back(RW'(r));
		data_q.push_back(d);
		tag_q.push_back(tag);
	endtask

	task automatic read_all(input int tag);
		for (int r = 0; r < DEPTH; r++) begin
			add_cmd(OP_READ, r, model[r], tag); // expected from the model
		end
	endtask

	// loads a whole board, then reads every row back
	task automatic add_board(input int tag);
		logic [WIDTH-1:0] pat [DEPTH];
		for (int r = 0; r < DEPTH; r++) begin
			pat[r] = '0;
		end
		case (tag)
			T_OSC: begin
				pat[4][3]  = 1'b1; // vertical blinker, col 3
				pat[5][3]  = 1'b1;
				pat[6][3]  = 1'b1;
				pat[8][10] = 1'b1; // block
				pat[8][11] = 1'b1;
				pat[9][10] = 1'b1;
				pat[9][11] = 1'b1;
			end
			T_GLIDER: begin
				// heading down-right, corner at row 10 col 14, already wrapped
				pat[10][15] = 1'b1;
				pat[11][0]  = 1'b1;
				pat[0][14]  = 1'b1;
				pat[0][15]  = 1'b1;
				pat[0][0]   = 1'b1;
			end
			T_RANDOM: begin
				for (int r = 0; r < DEPTH; r++) begin
					for (int b = 0; b < WIDTH; b++) begin
						lfsr      = lfsr_next(lfsr); // one step per bit
						pat[r][b] = lfsr[0];
					end
				end
			end
			T_SINGLE: pat[6][7] = 1'b1;
			default: ; // empty board
		endcase
		for (int r = 0; r < DEPTH; r++) begin
			add_cmd(OP_WRITE, r, pat[r], tag);
			model[r] = pat[r];
		end
		read_all(tag);
	endtask

	task automatic add_steps(input int tag, input int n);
		for (int s = 0; s < n; s++) begin
			add_cmd(OP_STEP, 0, '0, tag);
			repeat (GENS) advance_model();
			read_all(tag);
		end
	endtask

	// four-phase handshake for table entry i
	task automatic run_cmd(input int i);
		@(negedge clk);
		op    = op_q[i];
		row   = row_q[i];
		wdata = (op_q[i] == OP_WRITE) ? data_q[i] : '0;
		req   = 1'b1;
		do begin
			@(negedge clk);
		end while (!ack);
		if (op_q[i] == OP_READ) begin
			check_value($sformatf("%s cmd %0d row %0d", tag_name(tag_q[i]), i, row_q[i]),
				data_q[i], rdata);
		end
		repeat (2) @(negedge clk); // req kept up a while, ack and rdata must hold
		req = 1'b0;
		do begin
			@(negedge clk);
		end while (ack);
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		req   = 1'b0;
		op    = OP_WRITE;
		row   = '0;
		wdata = '0;
		rst   = 1'b1;
		lfsr  = 16'd44;

		add_board(T_OSC);     // readback before any swap
		add_steps(T_OSC, 1);
		add_board(T_GLIDER);  // from here on writes land after swaps
		add_steps(T_GLIDER, 4);
		add_board(T_RANDOM);
		add_steps(T_RANDOM, 5);
		add_board(T_EMPTY);
		add_steps(T_EMPTY, 1);
		add_board(T_SINGLE);
		add_steps(T_SINGLE, 1);
		limit = op_q.size() * (DEPTH + 4*GENS + 20) * 2;

		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		for (int i = 0; i < op_q.size(); i++) begin
			run_cmd(i);
		end

		if (err_count == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			$display("ERRORS FOUND");
			$fatal(1, "checks failed");
		end
	end

endmodule

`default_nettype wire
